// File: common/burst_mem_pkg.sv
// sizes, enums and the bank index for the banked burst memory
// each bank is 16 words deep; the upper address bits pick the bank
// NUM_BANKS must equal 2**BANK_SEL_W, the order queue wraps on that

package burst_mem_pkg;

  localparam int NUM_BANKS   = 4;
  localparam int BANK_SEL_W  = 2;
  localparam int BANK_ADDR_W = 4;                  // word address inside a bank
  localparam int BANK_DEPTH  = 2 ** BANK_ADDR_W;
  localparam int ADDR_W      = BANK_SEL_W + BANK_ADDR_W;
  localparam int DATA_W      = 32;

  localparam int BURST_LEN   = 4;                  // words per burst
  localparam int BEAT_W      = $clog2(BURST_LEN);
  localparam int CNT_W       = BEAT_W + 1;         // counts 0..BURST_LEN

  localparam int INIT_CYCLES = 10;                 // calibration after reset
  localparam int READ_DELAY  = 6;
  localparam int CALIB_CNT_W = $clog2(INIT_CYCLES) + 1;
  localparam int DELAY_CNT_W = $clog2(READ_DELAY) + 1;

  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } cmd_e;

  typedef enum logic [2:0] {
    BANK_INITIATE,
    BANK_IDLE,
    BANK_READ_DELAY,
    BANK_READ_BURST,
    BANK_WRITE_BURST
  } bank_state_e;

  typedef enum logic [1:0] {
    DSP_IDLE,
    DSP_GATHER,
    DSP_ISSUE,
    DSP_WRITE_STREAM
  } dispatch_state_e;

  typedef logic [BANK_SEL_W-1:0] bank_id_t;

endpackage

// File: common/burst_bank_if.sv
// command, write and read signals of one burst bank
// no back-pressure: the bank takes cmd_en only while idle with busy low
`timescale 1ns/1ns

interface burst_bank_if import burst_mem_pkg::*; ();

  cmd_e                   cmd;
  logic                   cmd_en;
  logic [BANK_ADDR_W-1:0] addr;
  logic [DATA_W-1:0]      wr_data;
  logic [DATA_W-1:0]      rd_data;
  logic                   rd_data_valid;
  logic                   init_calib;
  logic                   busy;

  modport dispatch (
    output cmd, cmd_en, addr, wr_data,
    input  busy, init_calib
  );

  modport bank (
    input  cmd, cmd_en, addr, wr_data,
    output rd_data, rd_data_valid, init_calib, busy
  );

  // read side only, the collector never drives the bank
  modport collect (
    input rd_data, rd_data_valid
  );

endinterface

// File: burst_bank/burst_bank.sv
// simulation model of a burst RAM with four-word bursts
// busy is high until calibration ends and during every burst
// commands are taken only while idle; memory contents are not reset
`timescale 1ns/1ns

module burst_bank import burst_mem_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  burst_bank_if.bank bus
);

  logic [DATA_W-1:0]      mem [BANK_DEPTH];

  bank_state_e            state;
  logic [CALIB_CNT_W-1:0] calib_cnt;
  logic [DELAY_CNT_W-1:0] delay_cnt;
  logic [BEAT_W-1:0]      burst_cnt;
  logic [BANK_ADDR_W-1:0] addr_cnt;   // wraps inside the bank

  logic                   take_cmd;
  logic                   last_beat;
  logic                   delay_done;
  logic                   mem_we;
  logic [BANK_ADDR_W-1:0] mem_waddr;
  logic                   rd_load;

  always_comb begin
    take_cmd   = (state == BANK_IDLE) && bus.cmd_en && !bus.busy;
    last_beat  = (burst_cnt == BEAT_W'(BURST_LEN - 1));
    delay_done = (delay_cnt == DELAY_CNT_W'(READ_DELAY - 1));

    // word 0 goes in with the command, words 1..3 in the burst state
    mem_we    = (take_cmd && bus.cmd == CMD_WRITE) ||
                (state == BANK_WRITE_BURST && !last_beat);
    mem_waddr = take_cmd ? bus.addr : addr_cnt;

    rd_load = (state == BANK_READ_DELAY && delay_done) ||
              (state == BANK_READ_BURST && !last_beat);
  end

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_waddr] <= bus.wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_load) begin
      bus.rd_data <= mem[addr_cnt];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state             <= BANK_INITIATE;
      calib_cnt         <= '0;
      delay_cnt         <= '0;
      burst_cnt         <= '0;
      addr_cnt          <= '0;
      bus.busy          <= 1'b1;
      bus.init_calib    <= 1'b0;
      bus.rd_data_valid <= 1'b0;
    end else begin
      unique case (state)
        BANK_INITIATE: begin
          if (calib_cnt == CALIB_CNT_W'(INIT_CYCLES)) begin
            bus.busy       <= 1'b0;
            bus.init_calib <= 1'b1;
            state          <= BANK_IDLE;
          end
          calib_cnt <= calib_cnt + 1'b1;
        end

        BANK_IDLE: begin
          if (take_cmd) begin
            bus.busy  <= 1'b1;
            burst_cnt <= '0;
            if (bus.cmd == CMD_READ) begin
              delay_cnt <= '0;
              addr_cnt  <= bus.addr;
              state     <= BANK_READ_DELAY;
            end else begin
              addr_cnt  <= bus.addr + 1'b1;   // first word already written
              state     <= BANK_WRITE_BURST;
            end
          end
        end

        BANK_READ_DELAY: begin
          if (delay_done) begin
            bus.rd_data_valid <= 1'b1;
            addr_cnt          <= addr_cnt + 1'b1;
            state             <= BANK_READ_BURST;
          end
          delay_cnt <= delay_cnt + 1'b1;
        end

        BANK_READ_BURST: begin
          burst_cnt <= burst_cnt + 1'b1;
          addr_cnt  <= addr_cnt + 1'b1;
          if (last_beat) begin
            bus.rd_data_valid <= 1'b0;
            bus.busy          <= 1'b0;
            state             <= BANK_IDLE;
          end
        end

        BANK_WRITE_BURST: begin
          burst_cnt <= burst_cnt + 1'b1;
          addr_cnt  <= addr_cnt + 1'b1;
          if (last_beat) begin   // no write in this cycle
            bus.busy <= 1'b0;
            state    <= BANK_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// File: hdl/burst_dispatch.sv
// accepts one request at a time, gathers a write burst, then issues it
// a read is issued only when its bank has a free collector slot
// writes stream one word per cycle after the command, no wait states
`timescale 1ns/1ns

module burst_dispatch import burst_mem_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  req_valid,
  output logic                  req_ready,
  input  cmd_e                  req_cmd,
  input  logic [ADDR_W-1:0]     req_addr,

  input  logic                  wdata_valid,
  output logic                  wdata_ready,
  input  logic [DATA_W-1:0]     wdata,

  input  logic [NUM_BANKS-1:0]  slot_free,
  output logic                  read_issue,
  output bank_id_t              read_bank,

  output logic                  mem_ready,

  burst_bank_if.dispatch        banks [NUM_BANKS]
);

  dispatch_state_e        state;
  cmd_e                   cur_cmd;
  bank_id_t               cur_bank;
  logic [BANK_ADDR_W-1:0] cur_addr;
  logic [BEAT_W-1:0]      beat_cnt;   // gather count, then stream count
  logic [DATA_W-1:0]      wbuf [BURST_LEN];

  logic [NUM_BANKS-1:0]   bank_busy;
  logic [NUM_BANKS-1:0]   bank_calib;
  logic                   bank_ok;
  logic                   cmd_fire;
  logic                   last_beat;

  genvar i;
  generate
    for (i = 0; i < NUM_BANKS; i++) begin : g_bank
      assign bank_busy[i]     = banks[i].busy;
      assign bank_calib[i]    = banks[i].init_calib;
      assign banks[i].cmd     = cur_cmd;
      assign banks[i].addr    = cur_addr;
      assign banks[i].wr_data = wbuf[beat_cnt];
      assign banks[i].cmd_en  = cmd_fire && (cur_bank == bank_id_t'(i));
    end
  endgenerate

  // reads also need room in the collector for the whole burst
  assign bank_ok = !bank_busy[cur_bank] && bank_calib[cur_bank] &&
                   (cur_cmd == CMD_WRITE || slot_free[cur_bank]);

  assign last_beat   = (beat_cnt == BEAT_W'(BURST_LEN - 1));
  assign read_issue  = (state == DSP_ISSUE) && bank_ok && (cur_cmd == CMD_READ);
  assign cmd_fire    = read_issue || (state == DSP_WRITE_STREAM && beat_cnt == '0);
  assign read_bank   = cur_bank;
  assign req_ready   = (state == DSP_IDLE) && mem_ready;
  assign wdata_ready = (state == DSP_GATHER);

  always_ff @(posedge clk) begin
    if (wdata_valid && wdata_ready) begin
      wbuf[beat_cnt] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= DSP_IDLE;
      cur_cmd   <= CMD_READ;
      cur_bank  <= '0;
      cur_addr  <= '0;
      beat_cnt  <= '0;
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= &bank_calib;

      unique case (state)
        DSP_IDLE: begin
          if (req_valid && req_ready) begin
            cur_cmd  <= req_cmd;
            cur_bank <= req_addr[ADDR_W-1 -: BANK_SEL_W];
            cur_addr <= req_addr[BANK_ADDR_W-1:0];
            beat_cnt <= '0;
            state    <= (req_cmd == CMD_WRITE) ? DSP_GATHER : DSP_ISSUE;
          end
        end

        DSP_GATHER: begin
          if (wdata_valid) begin
            beat_cnt <= beat_cnt + 1'b1;   // wraps back to 0 after the last word
            if (last_beat) state <= DSP_ISSUE;
          end
        end

        DSP_ISSUE: begin
          if (bank_ok) begin
            state <= (cur_cmd == CMD_READ) ? DSP_IDLE : DSP_WRITE_STREAM;
          end
        end

        DSP_WRITE_STREAM: begin
          beat_cnt <= beat_cnt + 1'b1;
          if (last_beat) state <= DSP_IDLE;
        end
      endcase
    end
  end

endmodule

// File: hdl/read_collector.sv
// buffers one read burst per bank and returns bursts in issue order
// a bank's slot stays reserved until its fourth word is accepted
// the order queue never overflows, each bank has at most one entry
`timescale 1ns/1ns

module read_collector import burst_mem_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 read_issue,
  input  bank_id_t             read_bank,
  output logic [NUM_BANKS-1:0] slot_free,

  output logic                 rdata_valid,
  input  logic                 rdata_ready,
  output logic [DATA_W-1:0]    rdata,

  burst_bank_if.collect        banks [NUM_BANKS]
);

  logic [DATA_W-1:0]     rbuf [NUM_BANKS][BURST_LEN];
  logic [CNT_W-1:0]      fill_cnt [NUM_BANKS];
  logic [CNT_W-1:0]      drain_cnt [NUM_BANKS];
  logic [NUM_BANKS-1:0]  reserved;

  bank_id_t              order_q [NUM_BANKS];
  bank_id_t              q_wr;
  bank_id_t              q_rd;
  logic [BANK_SEL_W:0]   q_count;
  bank_id_t              head;

  logic [NUM_BANKS-1:0]  beat_valid;
  logic [DATA_W-1:0]     beat_data [NUM_BANKS];
  logic                  rd_fire;
  logic                  burst_done;

  genvar i;
  generate
    for (i = 0; i < NUM_BANKS; i++) begin : g_bank
      assign beat_valid[i] = banks[i].rd_data_valid;
      assign beat_data[i]  = banks[i].rd_data;
    end
  endgenerate

  assign head        = order_q[q_rd];
  assign slot_free   = ~reserved;
  assign rdata_valid = (q_count != '0) && (drain_cnt[head] < fill_cnt[head]);
  assign rdata       = rbuf[head][drain_cnt[head][BEAT_W-1:0]];
  assign rd_fire     = rdata_valid && rdata_ready;
  assign burst_done  = rd_fire && (drain_cnt[head] == CNT_W'(BURST_LEN - 1));

  always_ff @(posedge clk) begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (beat_valid[b]) rbuf[b][fill_cnt[b][BEAT_W-1:0]] <= beat_data[b];
    end
    if (read_issue) order_q[q_wr] <= read_bank;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        fill_cnt[b]  <= '0;
        drain_cnt[b] <= '0;
      end
      reserved <= '0;
      q_wr     <= '0;
      q_rd     <= '0;
      q_count  <= '0;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (beat_valid[b]) fill_cnt[b] <= fill_cnt[b] + 1'b1;
      end

      if (read_issue) begin
        reserved[read_bank] <= 1'b1;
        q_wr                <= q_wr + 1'b1;
      end

      if (rd_fire) drain_cnt[head] <= drain_cnt[head] + 1'b1;

      if (burst_done) begin   // release the slot and pop the head
        fill_cnt[head]  <= '0;
        drain_cnt[head] <= '0;
        reserved[head]  <= 1'b0;
        q_rd            <= q_rd + 1'b1;
      end

      unique case ({read_issue, burst_done})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
    end
  end

endmodule

// File: hdl/burst_mem_top.sv
// banked burst memory: dispatcher, four burst banks and a read collector
// all channels are valid/ready; reads return in request order
// requests are accepted only after mem_ready, memory is not initialized
`timescale 1ns/1ns

module burst_mem_top import burst_mem_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              req_valid,
  output logic              req_ready,
  input  cmd_e              req_cmd,
  input  logic [ADDR_W-1:0] req_addr,

  input  logic              wdata_valid,
  output logic              wdata_ready,
  input  logic [DATA_W-1:0] wdata,

  output logic              rdata_valid,
  input  logic              rdata_ready,
  output logic [DATA_W-1:0] rdata,

  output logic              mem_ready
);

  burst_bank_if bank_bus [NUM_BANKS] ();

  logic                 read_issue;
  bank_id_t             read_bank;
  logic [NUM_BANKS-1:0] slot_free;

  burst_dispatch u_dispatch (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_cmd     (req_cmd),
    .req_addr    (req_addr),
    .wdata_valid (wdata_valid),
    .wdata_ready (wdata_ready),
    .wdata       (wdata),
    .slot_free   (slot_free),
    .read_issue  (read_issue),
    .read_bank   (read_bank),
    .mem_ready   (mem_ready),
    .banks       (bank_bus)
  );

  genvar i;
  generate
    for (i = 0; i < NUM_BANKS; i++) begin : g_bank
      burst_bank u_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bank_bus[i])
      );
    end
  endgenerate

  read_collector u_collector (
    .clk         (clk),
    .rst_n       (rst_n),
    .read_issue  (read_issue),
    .read_bank   (read_bank),
    .slot_free   (slot_free),
    .rdata_valid (rdata_valid),
    .rdata_ready (rdata_ready),
    .rdata       (rdata),
    .banks       (bank_bus)
  );

endmodule

// File: test/tb_burst_mem_tasks.svh
// reference memory, request and write data driving, read expectations
// tasks start and end 1 ns after a rising edge
`ifndef TB_BURST_MEM_TASKS_SVH
`define TB_BURST_MEM_TASKS_SVH

logic [DATA_W-1:0] ref_mem [NUM_BANKS*BANK_DEPTH];
bit                written [NUM_BANKS*BANK_DEPTH];

// flat reference index of one beat; the word address wraps inside the bank
function automatic logic [ADDR_W-1:0] beat_addr(input logic [ADDR_W-1:0] addr, input int beat);
  logic [BANK_ADDR_W-1:0] word;
  word = addr[BANK_ADDR_W-1:0] + BANK_ADDR_W'(beat);
  return {addr[ADDR_W-1 -: BANK_SEL_W], word};
endfunction

function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr,
                                                    input int beat);
  return ref_mem[beat_addr(addr, beat)];
endfunction

function automatic bit burst_written(input logic [ADDR_W-1:0] addr);
  bit ok;
  ok = 1'b1;
  for (int b = 0; b < BURST_LEN; b++) begin
    if (!written[beat_addr(addr, b)]) ok = 1'b0;
  end
  return ok;
endfunction

task automatic send_request(input cmd_e cmd, input logic [ADDR_W-1:0] addr);
  int waited;
  waited = 0;
  req_valid = 1'b1;
  req_cmd = cmd;
  req_addr = addr;
  while (!req_ready && waited < TIMEOUT_CYCLES) begin
    @(posedge clk);
    #1;
    waited++;
  end
  if (!req_ready) report_timeout("the request was never accepted");
  @(posedge clk);   // handshake on this edge
  #1;
  req_valid = 1'b0;
endtask

task automatic write_burst(input logic [ADDR_W-1:0] addr, input bit gaps);
  logic [DATA_W-1:0] word;
  int waited;
  send_request(CMD_WRITE, addr);
  for (int b = 0; b < BURST_LEN; b++) begin
    word = $urandom;
    ref_mem[beat_addr(addr, b)] = word;
    written[beat_addr(addr, b)] = 1'b1;
    if (gaps) begin
      repeat ($urandom_range(2)) begin
        @(posedge clk);
        #1;
      end
    end
    wdata_valid = 1'b1;
    wdata = word;
    waited = 0;
    while (!wdata_ready && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!wdata_ready) report_timeout("write data was never accepted");
    @(posedge clk);
    #1;
    wdata_valid = 1'b0;
  end
endtask

// expectations are taken at request time since earlier writes reach the bank first
task automatic issue_read(input logic [ADDR_W-1:0] addr);
  for (int b = 0; b < BURST_LEN; b++) begin
    exp_q.push_back(expected_word(addr, b));
  end
  send_request(CMD_READ, addr);
endtask

task automatic wait_drain();
  int waited;
  waited = 0;
  while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
    @(posedge clk);
    #1;
    waited++;
  end
  if (exp_q.size() != 0) report_timeout("read data did not come back");
endtask

`endif

// File: test/tb_burst_mem.sv
// testbench for the banked burst memory with directed and random bursts
// read words are compared in request order against a reference memory
`timescale 1ns/1ns

module tb_burst_mem import burst_mem_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 200;

  logic              clk;
  logic              rst_n;
  logic              req_valid;
  logic              req_ready;
  cmd_e              req_cmd;
  logic [ADDR_W-1:0] req_addr;
  logic              wdata_valid;
  logic              wdata_ready;
  logic [DATA_W-1:0] wdata;
  logic              rdata_valid;
  logic              rdata_ready;
  logic [DATA_W-1:0] rdata;
  logic              mem_ready;

  logic [DATA_W-1:0] exp_q [$];
  logic [DATA_W-1:0] exp_word;
  string             test_name;
  bit                stall_mode;   // random rdata_ready drops
  int                err_cnt;
  int                word_cnt;
  int                test_cnt;
  int                test_err_start;
  int                test_word_start;

  burst_mem_top DUT (.*);

  always #4 clk = ~clk;

  task automatic finish_run();
    $display("tests run %0d, words checked %0d, errors %0d", test_cnt, word_cnt, err_cnt);
    if (err_cnt == 0) $display("*** TEST PASSED ***");
    else $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout in test %s: %s", test_name, what);
    err_cnt++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err_start = err_cnt;
    test_word_start = word_cnt;
  endtask

  task automatic end_test();
    test_cnt++;
    $display("test %s done: %0d words checked, %0d errors", test_name,
             word_cnt - test_word_start, err_cnt - test_err_start);
  endtask

  `include "tb_burst_mem_tasks.svh"

  always @(posedge clk) begin
    #1;
    if (rst_n) rdata_ready = stall_mode ? ($urandom_range(3) != 0) : 1'b1;
  end

  // outputs and rdata_ready are both stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && rdata_valid && rdata_ready) begin
      assert (exp_q.size() != 0) else begin
        $display("read word %08h returned with no read pending in test %s", rdata, test_name);
        err_cnt++;
      end
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        word_cnt++;
        assert (rdata == exp_word) else begin
          $display("error %s: expected %08h, actual %08h", test_name, exp_word, rdata);
          err_cnt++;
        end
      end
    end
  end

  initial begin
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] addrs [4];
    int                waited;
    void'($urandom(32'h6b54));
    clk = 1'b0;
    rst_n = 1'b0;
    req_valid = 1'b0;
    req_cmd = CMD_READ;
    req_addr = '0;
    wdata_valid = 1'b0;
    wdata = '0;
    rdata_ready = 1'b0;
    stall_mode = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test("mem_ready after reset");
    waited = 0;
    while (!mem_ready && waited < TIMEOUT_CYCLES) begin
      assert (!req_ready) else begin
        $display("req_ready was high before mem_ready rose");
        err_cnt++;
      end
      @(posedge clk);
      #1;
      waited++;
    end
    if (!mem_ready) report_timeout("mem_ready never rose after reset");
    end_test();

    start_test("aligned write and read");
    write_burst(6'h04, 1'b0);
    issue_read(6'h04);
    wait_drain();
    end_test();

    start_test("wrap inside bank");
    write_burst(6'h10, 1'b0);
    write_burst(6'h0e, 1'b0);   // words 14, 15, 0, 1 of bank 0
    issue_read(6'h0e);
    issue_read(6'h10);
    issue_read(6'h04);
    wait_drain();
    end_test();

    start_test("reads to all banks in order");
    write_burst(6'h20, 1'b0);
    write_burst(6'h30, 1'b0);
    issue_read(6'h04);
    issue_read(6'h10);
    issue_read(6'h20);
    issue_read(6'h30);
    wait_drain();
    end_test();

    start_test("back-pressure and write gaps");
    stall_mode = 1'b1;
    for (int k = 0; k < 4; k++) begin
      addrs[k] = ADDR_W'($urandom);
      write_burst(addrs[k], 1'b1);
    end
    for (int k = 0; k < 4; k++) begin
      issue_read(addrs[k]);
    end
    wait_drain();
    stall_mode = 1'b0;
    end_test();

    start_test("random reads and writes");
    repeat (40) begin
      addr = ADDR_W'($urandom);
      if ($urandom_range(1) == 0 || !burst_written(addr)) write_burst(addr, 1'b0);
      else issue_read(addr);
    end
    wait_drain();
    end_test();

    finish_run();
  end

endmodule

// File: burst_mem.f
+incdir+test
common/burst_mem_pkg.sv
common/burst_bank_if.sv
burst_bank/burst_bank.sv
hdl/burst_dispatch.sv
hdl/read_collector.sv
hdl/burst_mem_top.sv
test/tb_burst_mem.sv
